// File: hw/cnn_cfg.svh
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// conv geometry
`define CNN_KSIZE 5
`define CNN_KAREA (`CNN_KSIZE * `CNN_KSIZE)
`define CNN_NCH 8                 // output channels, one PE each

// input tile held in the activation cache
`define CNN_TILE_W 8
`define CNN_TILE_H 6
`define CNN_NWIN 8                // 5x5 windows per tile

// BRAM word counts per job
`define CNN_W_WORDS 50            // 200 weights, 4 per word
`define CNN_IF_WORDS 12           // 48 pixels, 4 per word
`define CNN_OUT_WORDS 4           // 16 pooled bytes

`define CNN_BRAM_AW 32

// requantize by a plain right shift after relu
`define CNN_QSHIFT 7

// multiply stage plus sum stage
`define CNN_PE_LAT 2

`endif

// File: hw/cnn_data_pkg.sv
`include "cnn_cfg.svh"
`default_nettype none

package cnn_data_pkg;

  // activations and pooled outputs are unsigned
  typedef logic [7:0] pixel_t;

  typedef logic signed [7:0] weight_t;

  typedef logic signed [31:0] acc_t;

  typedef logic [31:0] word_t;

  typedef logic [`CNN_BRAM_AW-1:0] addr_t;

  // element r*5+c is window pixel (r,c)
  typedef pixel_t [`CNN_KAREA-1:0] window_t;

  // same element order as window_t
  typedef weight_t [`CNN_KAREA-1:0] kernel_t;

endpackage

`default_nettype wire

// File: hw/cnn_ctrl_pkg.sv
`include "cnn_cfg.svh"
`default_nettype none

package cnn_ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,     // weights and activations into the caches
    COMPUTE,  // one window per cycle
    DRAIN,    // window reg plus PE pipeline
    WRITE,    // pooled words to temp BRAM
    DONE
  } phase_t;

  // window index, bit 2 is the row offset, bits 1:0 the column
  typedef logic [$clog2(`CNN_NWIN)-1:0] tile_t;

  // temp word index
  typedef logic [$clog2(`CNN_OUT_WORDS)-1:0] slot_t;

endpackage

`default_nettype wire

// File: hw/cnn_ctrl.sv
`include "cnn_cfg.svh"
`default_nettype none

module cnn_ctrl
  import cnn_data_pkg::*, cnn_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_start,
  output logic       o_done,
  output addr_t      o_if_addr,
  output logic       o_if_en,
  output addr_t      o_w_addr,
  output logic       o_w_en,
  output logic       o_if_wr,
  output logic [3:0] o_if_wr_idx,
  output logic       o_w_wr,
  output logic [5:0] o_w_wr_idx,
  output logic       o_tile_load,
  output tile_t      o_tile,
  output slot_t      o_wr_slot,
  output addr_t      o_temp_addr,
  output logic       o_temp_en,
  output logic [3:0] o_temp_we
);

  phase_t     phase;
  logic [5:0] cnt;    // cycles spent in the current phase
  logic       last;   // final cycle of the phase

  always_comb begin
    case (phase)
      LOAD:    last = (cnt == 6'(`CNN_W_WORDS));  // one extra cycle for read latency
      COMPUTE: last = (cnt == 6'(`CNN_NWIN - 1));
      DRAIN:   last = (cnt == 6'(`CNN_PE_LAT));
      WRITE:   last = (cnt == 6'(`CNN_OUT_WORDS - 1));
      default: last = 1'b1;  // idle and done keep cnt at zero
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase <= IDLE;
      cnt   <= '0;
    end else begin
      cnt <= last ? 6'd0 : cnt + 6'd1;
      case (phase)
        IDLE:    if (i_start) phase <= LOAD;
        LOAD:    if (last) phase <= COMPUTE;
        COMPUTE: if (last) phase <= DRAIN;
        DRAIN:   if (last) phase <= WRITE;
        WRITE:   if (last) phase <= DONE;
        DONE:    phase <= IDLE;
        default: phase <= IDLE;
      endcase
    end
  end

  // BRAM reads, both streams start together
  assign o_w_en    = (phase == LOAD) && (cnt < 6'(`CNN_W_WORDS));
  assign o_if_en   = (phase == LOAD) && (cnt < 6'(`CNN_IF_WORDS));
  assign o_w_addr  = (phase == LOAD) ? addr_t'(cnt) : '0;
  assign o_if_addr = (phase == LOAD) ? addr_t'(cnt) : '0;

  // data shows up one cycle after the enable
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_w_wr      <= 1'b0;
      o_w_wr_idx  <= '0;
      o_if_wr     <= 1'b0;
      o_if_wr_idx <= '0;
    end else begin
      o_w_wr      <= o_w_en;
      o_w_wr_idx  <= cnt;
      o_if_wr     <= o_if_en;
      o_if_wr_idx <= cnt[3:0];
    end
  end

  // window order 0,1,4,5 then 2,3,6,7 keeps each pool group together
  assign o_tile_load = (phase == COMPUTE);
  assign o_tile      = tile_t'({cnt[1], cnt[2], cnt[0]});

  assign o_wr_slot   = (phase == WRITE) ? slot_t'(cnt[1:0]) : '0;
  assign o_temp_en   = (phase == WRITE);
  assign o_temp_we   = (phase == WRITE) ? 4'hf : 4'h0;
  assign o_temp_addr = (phase == WRITE) ? addr_t'(cnt) : '0;

  assign o_done = (phase == DONE);

  a_we_needs_en: assert property (@(posedge clk) disable iff (rst)
    (o_temp_we != 4'h0) |-> o_temp_en);

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    o_done |=> !o_done);

endmodule

`default_nettype wire

// File: hw/ifmap_cache.sv
`include "cnn_cfg.svh"
`default_nettype none

module ifmap_cache
  import cnn_data_pkg::*, cnn_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_wr,
  input  logic [3:0] i_wr_idx,
  input  word_t      i_word,
  input  logic       i_tile_load,
  input  tile_t      i_tile,
  output window_t    o_window,
  output logic       o_win_valid
);

  // row-major, pixel (row,col) at row*8+col
  pixel_t cache [`CNN_TILE_W * `CNN_TILE_H];

  int row_base;
  int col_base;

  assign row_base = int'(i_tile[2]);
  assign col_base = int'(i_tile[1:0]);

  // first pixel of the word sits in the top byte
  always_ff @(posedge clk) begin
    if (i_wr) begin
      for (int b = 0; b < 4; b++) begin
        cache[int'(i_wr_idx) * 4 + b] <= i_word[31 - 8*b -: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_tile_load) begin
      for (int r = 0; r < `CNN_KSIZE; r++) begin
        for (int c = 0; c < `CNN_KSIZE; c++) begin
          o_window[r*`CNN_KSIZE + c] <=
            cache[(row_base + r) * `CNN_TILE_W + col_base + c];
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_win_valid <= 1'b0;
    end else begin
      o_win_valid <= i_tile_load;
    end
  end

endmodule

`default_nettype wire

// File: hw/weight_cache.sv
`include "cnn_cfg.svh"
`default_nettype none

module weight_cache
  import cnn_data_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_wr,
  input  logic [5:0] i_wr_idx,
  input  word_t      i_word,
  output kernel_t    o_kernels [`CNN_NCH]
);

  weight_t wmem [`CNN_NCH * `CNN_KAREA];

  always_ff @(posedge clk) begin
    if (i_wr) begin
      for (int b = 0; b < 4; b++) begin
        wmem[int'(i_wr_idx) * 4 + b] <= weight_t'(i_word[31 - 8*b -: 8]);
      end
    end
  end

  // kernels are stored back to back, 25 weights each
  always_comb begin
    for (int k = 0; k < `CNN_NCH; k++) begin
      for (int j = 0; j < `CNN_KAREA; j++) begin
        o_kernels[k][j] = wmem[k*`CNN_KAREA + j];
      end
    end
  end

  a_wr_idx_range: assert property (@(posedge clk) disable iff (rst)
    i_wr |-> (i_wr_idx < 6'(`CNN_W_WORDS)));

endmodule

`default_nettype wire

// File: hw/conv_pe.sv
`include "cnn_cfg.svh"
`default_nettype none

module conv_pe
  import cnn_data_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    i_valid,
  input  window_t i_window,
  input  kernel_t i_kernel,
  output logic    o_valid,
  output pixel_t  o_result
);

  // 9-bit unsigned-as-signed pixel times 8-bit weight
  logic signed [16:0] prod_q [`CNN_KAREA];
  logic               valid_q;
  acc_t               sum;
  acc_t               scaled;

  always_ff @(posedge clk) begin
    if (i_valid) begin
      for (int k = 0; k < `CNN_KAREA; k++) begin
        prod_q[k] <= $signed({1'b0, i_window[k]}) * $signed(i_kernel[k]);
      end
    end
  end

  always_comb begin
    sum = '0;
    for (int k = 0; k < `CNN_KAREA; k++) begin
      sum = sum + acc_t'(prod_q[k]);
    end
  end

  assign scaled = sum >>> `CNN_QSHIFT;

  // relu, then clamp to a byte
  always_ff @(posedge clk) begin
    if (valid_q) begin
      if (sum < 0) begin
        o_result <= '0;
      end else if (scaled > acc_t'(255)) begin
        o_result <= 8'hff;
      end else begin
        o_result <= scaled[7:0];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      valid_q <= i_valid;
      o_valid <= valid_q;
    end
  end

endmodule

`default_nettype wire

// File: hw/pool_pack.sv
`include "cnn_cfg.svh"
`default_nettype none

module pool_pack
  import cnn_data_pkg::*, cnn_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   i_valid,
  input  pixel_t i_results [`CNN_NCH],
  input  slot_t  i_wr_slot,
  output word_t  o_word
);

  pixel_t     hist   [`CNN_NCH][3];  // three older results, newest at 0
  pixel_t     pool_q [2][`CNN_NCH];  // pooled byte per group and channel
  pixel_t     win_max [`CNN_NCH];
  logic [1:0] vcnt;                  // valids within the group
  logic       grp;
  logic [3:0] job_cnt;
  int         rd_base;

  function automatic pixel_t max2(input pixel_t a, input pixel_t b);
    return (a > b) ? a : b;
  endfunction

  // incoming result completes the 2x2 block
  always_comb begin
    for (int ch = 0; ch < `CNN_NCH; ch++) begin
      win_max[ch] = max2(max2(i_results[ch], hist[ch][0]),
                         max2(hist[ch][1], hist[ch][2]));
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      for (int ch = 0; ch < `CNN_NCH; ch++) begin
        hist[ch][0] <= i_results[ch];
        hist[ch][1] <= hist[ch][0];
        hist[ch][2] <= hist[ch][1];
        if (vcnt == 2'd3) begin
          pool_q[grp][ch] <= win_max[ch];
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vcnt    <= '0;
      grp     <= 1'b0;
      job_cnt <= '0;
    end else begin
      if (i_valid) begin
        vcnt <= vcnt + 2'd1;
        if (vcnt == 2'd3) grp <= ~grp;
      end
      if (i_wr_slot == 2'd3) begin
        job_cnt <= '0;  // last temp word closes the job
      end else if (i_valid) begin
        job_cnt <= job_cnt + 4'd1;
      end
    end
  end

  // slot bit 1 picks the group, bit 0 the channel half
  assign rd_base = int'(i_wr_slot[0]) * 4;

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      o_word[31 - 8*b -: 8] = pool_q[i_wr_slot[1]][rd_base + b];
    end
  end

  a_valids_per_job: assert property (@(posedge clk) disable iff (rst)
    i_valid |-> (job_cnt < 4'(`CNN_NWIN)));

endmodule

`default_nettype wire

// File: hw/cnn_top.sv
`include "cnn_cfg.svh"
`default_nettype none

module cnn_top
  import cnn_data_pkg::*, cnn_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_start,
  output logic       o_done,
  output addr_t      o_if_addr,
  output logic       o_if_en,
  input  word_t      i_if_dout,
  output addr_t      o_w_addr,
  output logic       o_w_en,
  input  word_t      i_w_dout,
  output addr_t      o_temp_addr,
  output logic       o_temp_en,
  output logic [3:0] o_temp_we,
  output word_t      o_temp_din
);

  logic               if_wr;
  logic [3:0]         if_wr_idx;
  logic               w_wr;
  logic [5:0]         w_wr_idx;
  logic               tile_load;
  tile_t              tile;
  slot_t              wr_slot;
  window_t            window;
  logic               win_valid;
  kernel_t            kernels [`CNN_NCH];
  pixel_t             results [`CNN_NCH];
  logic [`CNN_NCH-1:0] res_valid;  // all channels in lockstep

  cnn_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .o_done      (o_done),
    .o_if_addr   (o_if_addr),
    .o_if_en     (o_if_en),
    .o_w_addr    (o_w_addr),
    .o_w_en      (o_w_en),
    .o_if_wr     (if_wr),
    .o_if_wr_idx (if_wr_idx),
    .o_w_wr      (w_wr),
    .o_w_wr_idx  (w_wr_idx),
    .o_tile_load (tile_load),
    .o_tile      (tile),
    .o_wr_slot   (wr_slot),
    .o_temp_addr (o_temp_addr),
    .o_temp_en   (o_temp_en),
    .o_temp_we   (o_temp_we)
  );

  ifmap_cache u_ifmap (
    .clk         (clk),
    .rst         (rst),
    .i_wr        (if_wr),
    .i_wr_idx    (if_wr_idx),
    .i_word      (i_if_dout),
    .i_tile_load (tile_load),
    .i_tile      (tile),
    .o_window    (window),
    .o_win_valid (win_valid)
  );

  weight_cache u_wcache (
    .clk       (clk),
    .rst       (rst),
    .i_wr      (w_wr),
    .i_wr_idx  (w_wr_idx),
    .i_word    (i_w_dout),
    .o_kernels (kernels)
  );

  // same window to every PE, one kernel each
  for (genvar g = 0; g < `CNN_NCH; g++) begin : g_pe
    conv_pe u_pe (
      .clk      (clk),
      .rst      (rst),
      .i_valid  (win_valid),
      .i_window (window),
      .i_kernel (kernels[g]),
      .o_valid  (res_valid[g]),
      .o_result (results[g])
    );
  end

  pool_pack u_pool (
    .clk       (clk),
    .rst       (rst),
    .i_valid   (res_valid[0]),
    .i_results (results),
    .i_wr_slot (wr_slot),
    .o_word    (o_temp_din)
  );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
  output logic o_clk
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam time HALF_PERIOD = 20ns;  // 40 ns clock

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

// File: tb/tb_checker.sv
`include "cnn_cfg.svh"
`default_nettype none

module tb_checker
  import cnn_data_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_start,
  input  logic       i_done,
  input  addr_t      i_temp_addr,
  input  logic       i_temp_en,
  input  logic [3:0] i_temp_we,
  input  word_t      i_temp_din,
  output int         o_errors,
  output int         o_jobs
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int JOB_CYCLES = 67;  // start edge to the edge that sees done

  word_t exp_words [`CNN_OUT_WORDS];
  logic  written   [`CNN_OUT_WORDS];
  logic  busy;
  int    cyc;

  // unsigned tile pixel (y,x)
  function automatic int pixel_at(input int y, input int x);
    int idx;
    idx = y * `CNN_TILE_W + x;
    return int'(tb_cnn.if_mem[idx / 4][31 - 8*(idx % 4) -: 8]);
  endfunction

  function automatic int weight_at(input int i);
    logic signed [7:0] w;
    w = tb_cnn.w_mem[i / 4][31 - 8*(i % 4) -: 8];
    return int'(w);
  endfunction

  // max of the relu and requant results over one pool group
  function automatic int pooled(input int ch, input int grp);
    int best;
    int sum;
    int q;
    int row;
    int col;
    best = 0;
    for (int t = 0; t < `CNN_NWIN; t++) begin
      row = t / 4;
      col = t % 4;
      if (col / 2 == grp) begin  // left half is group 0
        sum = 0;
        for (int r = 0; r < `CNN_KSIZE; r++) begin
          for (int c = 0; c < `CNN_KSIZE; c++) begin
            sum += pixel_at(row + r, col + c) * weight_at(ch * `CNN_KAREA + r * `CNN_KSIZE + c);
          end
        end
        q = (sum < 0) ? 0 : (sum >>> `CNN_QSHIFT);
        if (q > 255) q = 255;
        if (q > best) best = q;
      end
    end
    return best;
  endfunction

  task automatic build_expected();
    for (int w = 0; w < `CNN_OUT_WORDS; w++) begin
      exp_words[w] = '0;
      written[w]   = 1'b0;
    end
    for (int g = 0; g < 2; g++) begin
      for (int ch = 0; ch < `CNN_NCH; ch++) begin
        exp_words[2*g + ch/4][31 - 8*(ch % 4) -: 8] = 8'(pooled(ch, g));
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      busy     = 1'b0;
      cyc      = 0;
      o_errors = 0;
      o_jobs   = 0;
    end else begin
      if (busy) cyc++;
      if (i_start && !busy) begin
        busy = 1'b1;
        cyc  = 0;
        build_expected();  // arrays are stable for the whole job
      end
      if ((i_temp_en || i_temp_we != 4'h0) && !(i_temp_en && i_temp_we == 4'hf)) begin
        $display("%s: temp enable %0b does not match byte write enables %h",
                 tb_cnn.test_name, i_temp_en, i_temp_we);
        o_errors++;
      end
      if (i_temp_en && i_temp_we != 4'h0) begin
        if (!busy) begin
          $display("temp write seen while no job was running");
          o_errors++;
        end else if (i_temp_addr >= addr_t'(`CNN_OUT_WORDS)) begin
          $display("%s: temp write to address %0d, outside 0..3", tb_cnn.test_name, i_temp_addr);
          o_errors++;
        end else if (written[i_temp_addr[1:0]]) begin
          $display("%s: temp address %0d written twice", tb_cnn.test_name, i_temp_addr);
          o_errors++;
        end else begin
          written[i_temp_addr[1:0]] = 1'b1;
          if (i_temp_din !== exp_words[i_temp_addr[1:0]]) begin
            $display("FAIL %s word %0d: expected %08h, actual %08h", tb_cnn.test_name,
                     i_temp_addr, exp_words[i_temp_addr[1:0]], i_temp_din);
            o_errors++;
          end
        end
      end
      if (i_done) begin
        if (!busy) begin
          $display("done pulse seen while no job was running");
          o_errors++;
        end else begin
          if (cyc != JOB_CYCLES) begin
            $display("FAIL %s done latency: expected %0d, actual %0d", tb_cnn.test_name,
                     JOB_CYCLES, cyc);
            o_errors++;
          end
          for (int w = 0; w < `CNN_OUT_WORDS; w++) begin
            if (!written[w]) begin
              $display("%s: temp address %0d was never written", tb_cnn.test_name, w);
              o_errors++;
            end
          end
          o_jobs++;
          busy = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_cnn.sv
`include "cnn_cfg.svh"
`default_nettype none

module tb_cnn
  import cnn_data_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NTESTS = 8;
  localparam int TIMEOUT_CYCLES = NTESTS * 80 + 20;

  // fill patterns
  localparam int PAT_ZERO = 0;
  localparam int PAT_RAND = 1;
  localparam int PAT_MAX  = 2;
  localparam int PAT_NEG  = 3;
  localparam int PAT_ONE  = 4;
  localparam int PAT_DOT  = 5;  // one pixel at 255, rest zero
  localparam int PAT_RAMP = 6;

  string tbl_name [NTESTS] = '{"zero_weights", "negative_weights", "saturate",
                               "dot_top_left", "dot_bottom_right", "dot_right_half",
                               "random_a", "random_b"};
  int    tbl_pix  [NTESTS] = '{PAT_RAND, PAT_RAMP, PAT_MAX, PAT_DOT, PAT_DOT, PAT_DOT,
                               PAT_RAND, PAT_RAND};
  int    tbl_wgt  [NTESTS] = '{PAT_ZERO, PAT_NEG, PAT_MAX, PAT_ONE, PAT_ONE, PAT_ONE,
                               PAT_RAND, PAT_RAND};
  // pixel index y*8+x of the dot, (0,0) (5,7) (4,6)
  int    tbl_dot  [NTESTS] = '{0, 0, 0, 0, 47, 38, 0, 0};

  logic       clk;
  logic       rst;
  logic       i_start;
  logic       o_done;
  addr_t      o_if_addr;
  logic       o_if_en;
  word_t      if_dout = '0;
  addr_t      o_w_addr;
  logic       o_w_en;
  word_t      w_dout = '0;
  addr_t      o_temp_addr;
  logic       o_temp_en;
  logic [3:0] o_temp_we;
  word_t      o_temp_din;

  word_t  if_mem [`CNN_IF_WORDS];
  word_t  w_mem  [`CNN_W_WORDS];
  string  test_name = "reset";
  integer seed;
  int     cycles = 0;
  int     errors;
  int     jobs;
  int     local_errors = 0;

  tb_clk_gen u_clk (.o_clk(clk));

  cnn_top DUT (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .o_done      (o_done),
    .o_if_addr   (o_if_addr),
    .o_if_en     (o_if_en),
    .i_if_dout   (if_dout),
    .o_w_addr    (o_w_addr),
    .o_w_en      (o_w_en),
    .i_w_dout    (w_dout),
    .o_temp_addr (o_temp_addr),
    .o_temp_en   (o_temp_en),
    .o_temp_we   (o_temp_we),
    .o_temp_din  (o_temp_din)
  );

  tb_checker u_check (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .i_done      (o_done),
    .i_temp_addr (o_temp_addr),
    .i_temp_en   (o_temp_en),
    .i_temp_we   (o_temp_we),
    .i_temp_din  (o_temp_din),
    .o_errors    (errors),
    .o_jobs      (jobs)
  );

  // read-only BRAMs, one cycle latency
  always @(posedge clk) begin
    if (o_if_en) if_dout <= if_mem[o_if_addr[3:0]];
    if (o_w_en) w_dout <= w_mem[o_w_addr[5:0]];
  end

  function automatic logic [7:0] pixel_byte(input int pat, input int idx, input int dot);
    case (pat)
      PAT_RAND: return 8'($random(seed));
      PAT_MAX:  return 8'hff;
      PAT_RAMP: return 8'(idx + 1);  // never zero
      PAT_DOT:  return (idx == dot) ? 8'hff : 8'h00;
      default:  return 8'h00;
    endcase
  endfunction

  function automatic logic [7:0] weight_byte(input int pat);
    case (pat)
      PAT_RAND: return 8'($random(seed));
      PAT_MAX:  return 8'h7f;
      PAT_NEG:  return 8'h80 | 8'($random(seed));  // sign bit forced
      PAT_ONE:  return 8'h01;
      default:  return 8'h00;
    endcase
  endfunction

  task automatic fill_memories(input int pix_pat, input int wgt_pat, input int dot);
    for (int i = 0; i < `CNN_IF_WORDS * 4; i++) begin
      if_mem[i / 4][31 - 8*(i % 4) -: 8] = pixel_byte(pix_pat, i, dot);
    end
    for (int i = 0; i < `CNN_W_WORDS * 4; i++) begin
      w_mem[i / 4][31 - 8*(i % 4) -: 8] = weight_byte(wgt_pat);
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a job never finished", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    seed    = 32'hd6e5;
    rst     = 1'b1;
    i_start = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    for (int t = 0; t < NTESTS; t++) begin
      test_name = tbl_name[t];
      fill_memories(tbl_pix[t], tbl_wgt[t], tbl_dot[t]);
      i_start = 1'b1;
      @(negedge clk);
      i_start = 1'b0;
      do @(negedge clk); while (!o_done);
      @(negedge clk);  // back in idle, next job starts right away
    end
    repeat (2) @(negedge clk);
    if (jobs != NTESTS) begin
      $display("only %0d of %0d jobs signalled done", jobs, NTESTS);
      local_errors++;
    end
    $display("errors: %0d, jobs: %0d of %0d", errors + local_errors, jobs, NTESTS);
    if (errors + local_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/cnn_data_pkg.sv
hw/cnn_ctrl_pkg.sv
hw/cnn_ctrl.sv
hw/ifmap_cache.sv
hw/weight_cache.sv
hw/conv_pe.sv
hw/pool_pack.sv
hw/cnn_top.sv
tb/tb_clk_gen.sv
tb/tb_checker.sv
tb/tb_cnn.sv

// File: Makefile
SRCS := $(wildcard hw/*.sv hw/*.svh tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_cnn: $(SRCS) sources.f
	verilator --binary --timing --assert -j 0 -Wno-fatal --top-module tb_cnn -f sources.f

run: obj_dir/Vtb_cnn
	./obj_dir/Vtb_cnn | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
